// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_axi_wr_stats
TRACE     ?= 0
VECTORS   ?= verif/axi_wr_stats_vectors.txt
FILELIST  ?= filelist.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
LINTFLAGS ?= --lint-only --timing -Wall

SOURCES := $(shell cat $(FILELIST))

ifeq ($(TRACE),1)
VFLAGS += --trace
endif

.PHONY: all run build lint clean

all: run

build: $(OBJ_DIR)/V$(TOP)

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

run: build $(VECTORS)
	./$(OBJ_DIR)/V$(TOP)

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(OBJ_DIR)

// ==== filelist.f ====
source/axi_wr_stats_pkg.sv
source/stat_accumulator.sv
source/stat_iterator.sv
source/axi_wr_event_decoder.sv
source/axi_wr_stats_top.sv
verif/tb_axi_wr_stats.sv

// ==== source/axi_wr_event_decoder.sv ====
`timescale 1ns/1ps

module axi_wr_event_decoder #(
  parameter int STAT_WIDTH     = 32,
  parameter int AXI_STRB_WIDTH = 2
) (
  input  logic                                                   clk,
  input  logic                                                   rst_n,
  input  logic                                                   stat_clear,
  input  axi_wr_stats_pkg::axi_wr_ctl_t                          axi_ctl,
  input  logic [AXI_STRB_WIDTH-1:0]                              wstrb,
  output logic [axi_wr_stats_pkg::NUM_STATS-1:0][STAT_WIDTH-1:0] stat_inc,
  output logic                                                   stat_err
);

  // depth of the outstanding transaction counters
  localparam int CNT_WIDTH = 8;

  axi_wr_stats_pkg::axi_wr_ctl_t ctl_q;
  logic [AXI_STRB_WIDTH-1:0]     wstrb_q;
  logic                          sample_valid;

  logic [CNT_WIDTH-1:0] aw_pending;
  logic [CNT_WIDTH-1:0] b_pending;
  logic                 w_in_progress;

  logic aw_hs;
  logic w_hs;
  logic w_last_hs;
  logic b_hs;
  logic orphan_b;

  function automatic logic [STAT_WIDTH-1:0] strobe_bytes(input logic [AXI_STRB_WIDTH-1:0] strb);
    logic [STAT_WIDTH-1:0] n;
    n = '0;
    for (int i = 0; i < AXI_STRB_WIDTH; i++) begin
      n = n + STAT_WIDTH'(strb[i]);
    end
    return n;
  endfunction

  // bus sample, dropped on clear so the clear cycle is never counted
  always_ff @(posedge clk) begin
    if (!rst_n || stat_clear) begin
      ctl_q        <= '0;
      sample_valid <= 1'b0;
    end else begin
      ctl_q        <= axi_ctl;
      sample_valid <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    wstrb_q <= wstrb;
  end

  assign aw_hs     = ctl_q.awvalid && ctl_q.awready;
  assign w_hs      = ctl_q.wvalid && ctl_q.wready;
  assign w_last_hs = w_hs && ctl_q.wlast;
  assign b_hs      = ctl_q.bvalid && ctl_q.bready;

  // a response with no address behind it
  assign orphan_b = b_hs && (aw_pending == '0);

  // aw_pending runs from AW accept to B accept,
  // b_pending from the wlast accept to B accept
  always_ff @(posedge clk) begin
    if (!rst_n || stat_clear) begin
      aw_pending    <= '0;
      b_pending     <= '0;
      w_in_progress <= 1'b0;
    end else begin
      aw_pending <= aw_pending + CNT_WIDTH'(aw_hs)
                    - CNT_WIDTH'(b_hs && (aw_pending != '0));
      b_pending  <= b_pending + CNT_WIDTH'(w_last_hs)
                    - CNT_WIDTH'(b_hs && (b_pending != '0));
      if (w_hs) begin
        w_in_progress <= !ctl_q.wlast;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n || stat_clear) begin
      stat_err <= 1'b0;
    end else if (orphan_b) begin
      stat_err <= 1'b1;
    end
  end

  always_comb begin
    stat_inc = '0;
    if (sample_valid) begin
      // transfer counts
      stat_inc[axi_wr_stats_pkg::AW_BURSTS] = STAT_WIDTH'(aw_hs);
      stat_inc[axi_wr_stats_pkg::W_BEATS]   = STAT_WIDTH'(w_hs);
      stat_inc[axi_wr_stats_pkg::W_BURSTS]  = STAT_WIDTH'(w_last_hs);
      stat_inc[axi_wr_stats_pkg::B_RESPS]   = STAT_WIDTH'(b_hs);
      stat_inc[axi_wr_stats_pkg::ERR_RESPS] = STAT_WIDTH'(b_hs && ctl_q.bresp[1]);

      // byte counts
      if (aw_hs) begin
        stat_inc[axi_wr_stats_pkg::AW_BYTES] =
          (STAT_WIDTH'(ctl_q.awlen) + STAT_WIDTH'(1)) << ctl_q.awsize;
      end
      if (w_hs) begin
        stat_inc[axi_wr_stats_pkg::W_BYTES] = strobe_bytes(wstrb_q);
      end

      // cycle buckets
      stat_inc[axi_wr_stats_pkg::IDLE_CYCLES] = STAT_WIDTH'((aw_pending == '0) &&
        !w_in_progress && !ctl_q.awvalid && !ctl_q.wvalid);
      stat_inc[axi_wr_stats_pkg::W_STALL] = STAT_WIDTH'(ctl_q.wvalid && !ctl_q.wready);
      stat_inc[axi_wr_stats_pkg::W_SLOW]  = STAT_WIDTH'(w_in_progress && !ctl_q.wvalid);
      stat_inc[axi_wr_stats_pkg::B_LAG]   = STAT_WIDTH'((b_pending != '0) &&
        !w_in_progress && !ctl_q.bvalid);
      stat_inc[axi_wr_stats_pkg::B_STALL] = STAT_WIDTH'(ctl_q.bvalid && !ctl_q.bready);
    end
  end

endmodule

// ==== source/axi_wr_stats_pkg.sv ====
package axi_wr_stats_pkg;

  // number of statistics and the characters in each name
  localparam int NUM_STATS     = 12;
  localparam int STAT_NAME_LEN = 16;

  typedef logic [STAT_NAME_LEN*8-1:0] stat_name_t;
  typedef logic [3:0]                 stat_idx_t;

  // stat indices, also the order of the dump
  localparam stat_idx_t AW_BURSTS   = 4'd0;
  localparam stat_idx_t W_BEATS     = 4'd1;
  localparam stat_idx_t W_BURSTS    = 4'd2;
  localparam stat_idx_t B_RESPS     = 4'd3;
  localparam stat_idx_t AW_BYTES    = 4'd4;
  localparam stat_idx_t W_BYTES     = 4'd5;
  localparam stat_idx_t IDLE_CYCLES = 4'd6;
  localparam stat_idx_t W_STALL     = 4'd7;
  localparam stat_idx_t W_SLOW      = 4'd8;
  localparam stat_idx_t B_LAG       = 4'd9;
  localparam stat_idx_t B_STALL     = 4'd10;
  localparam stat_idx_t ERR_RESPS   = 4'd11;

  // names are space padded to the full sixteen characters
  localparam stat_name_t STAT_NAMES [NUM_STATS] = '{
    "aw_bursts       ",
    "w_beats         ",
    "w_bursts        ",
    "b_resps         ",
    "aw_bytes        ",
    "w_bytes         ",
    "idle_cycles     ",
    "w_stall         ",
    "w_slow          ",
    "b_lag           ",
    "b_stall         ",
    "err_resps       "
  };

  // handshake fields of the AXI write channels
  typedef struct packed {
    logic       awvalid;
    logic       awready;
    logic [7:0] awlen;
    logic [2:0] awsize;
    logic       wvalid;
    logic       wready;
    logic       wlast;
    logic       bvalid;
    logic       bready;
    logic [1:0] bresp;
  } axi_wr_ctl_t;

  typedef enum logic [1:0] {
    IDLE,
    SEND,
    DONE
  } iter_state_e;

endpackage

// ==== source/axi_wr_stats_top.sv ====
`timescale 1ns/1ps

module axi_wr_stats_top #(
  parameter int STAT_WIDTH     = 32,
  parameter int AXI_STRB_WIDTH = 2
) (
  input  logic                          clk,
  input  logic                          rst_n,
  input  axi_wr_stats_pkg::axi_wr_ctl_t axi_ctl,
  input  logic [AXI_STRB_WIDTH-1:0]     wstrb,
  input  logic                          stat_clear,
  input  logic                          stat_iter_start,
  output logic                          stat_err,
  output logic                          stat_iter_valid,
  output axi_wr_stats_pkg::stat_name_t  stat_iter_name,
  output logic [STAT_WIDTH-1:0]         stat_iter_val,
  output logic                          stat_iter_last,
  input  logic                          stat_iter_ready
);

  logic [axi_wr_stats_pkg::NUM_STATS-1:0][STAT_WIDTH-1:0] stat_inc;
  logic [axi_wr_stats_pkg::NUM_STATS-1:0][STAT_WIDTH-1:0] stat_snap;
  logic                                                   snapshot;
  axi_wr_stats_pkg::stat_idx_t                            rd_idx;
  logic [STAT_WIDTH-1:0]                                  rd_val;

  axi_wr_event_decoder #(
    .STAT_WIDTH    (STAT_WIDTH),
    .AXI_STRB_WIDTH(AXI_STRB_WIDTH)
  ) i_decoder (
    .clk       (clk),
    .rst_n     (rst_n),
    .stat_clear(stat_clear),
    .axi_ctl   (axi_ctl),
    .wstrb     (wstrb),
    .stat_inc  (stat_inc),
    .stat_err  (stat_err)
  );

  // one running sum per statistic
  for (genvar i = 0; i < axi_wr_stats_pkg::NUM_STATS; i++) begin : g_stat
    stat_accumulator #(
      .STAT_WIDTH(STAT_WIDTH)
    ) i_acc (
      .clk       (clk),
      .rst_n     (rst_n),
      .stat_clear(stat_clear),
      .snapshot  (snapshot),
      .inc       (stat_inc[i]),
      .sum       (),
      .snap      (stat_snap[i])
    );
  end

  // read select, indices past the table read as zero
  always_comb begin
    rd_val = '0;
    if (rd_idx < axi_wr_stats_pkg::NUM_STATS) begin
      rd_val = stat_snap[rd_idx];
    end
  end

  stat_iterator #(
    .STAT_WIDTH(STAT_WIDTH)
  ) i_iter (
    .clk            (clk),
    .rst_n          (rst_n),
    .stat_iter_start(stat_iter_start),
    .snapshot       (snapshot),
    .rd_idx         (rd_idx),
    .rd_val         (rd_val),
    .stat_iter_valid(stat_iter_valid),
    .stat_iter_name (stat_iter_name),
    .stat_iter_val  (stat_iter_val),
    .stat_iter_last (stat_iter_last),
    .stat_iter_ready(stat_iter_ready)
  );

endmodule

// ==== source/stat_accumulator.sv ====
`timescale 1ns/1ps

module stat_accumulator #(
  parameter int STAT_WIDTH = 32
) (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  stat_clear,
  input  logic                  snapshot,
  input  logic [STAT_WIDTH-1:0] inc,
  output logic [STAT_WIDTH-1:0] sum,
  output logic [STAT_WIDTH-1:0] snap
);

  logic [STAT_WIDTH-1:0] sum_next;

  // clear also drops the amount arriving in the same cycle
  assign sum_next = stat_clear ? '0 : sum + inc;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      sum <= '0;
    end else begin
      sum <= sum_next;
    end
  end

  // snapshot takes the value including this cycle's amount
  always_ff @(posedge clk) begin
    if (snapshot) begin
      snap <= sum_next;
    end
  end

  // a running sum only grows between clears
  a_no_wrap: assert property (
    @(posedge clk) disable iff (!rst_n)
      !stat_clear |=> sum >= $past(sum)
  ) else $error("stat_accumulator: sum wrapped");

endmodule

// ==== source/stat_iterator.sv ====
`timescale 1ns/1ps

module stat_iterator #(
  parameter int STAT_WIDTH = 32
) (
  input  logic                         clk,
  input  logic                         rst_n,
  input  logic                         stat_iter_start,
  output logic                         snapshot,
  output axi_wr_stats_pkg::stat_idx_t  rd_idx,
  input  logic [STAT_WIDTH-1:0]        rd_val,
  output logic                         stat_iter_valid,
  output axi_wr_stats_pkg::stat_name_t stat_iter_name,
  output logic [STAT_WIDTH-1:0]        stat_iter_val,
  output logic                         stat_iter_last,
  input  logic                         stat_iter_ready
);

  localparam axi_wr_stats_pkg::stat_idx_t LAST_IDX =
    axi_wr_stats_pkg::stat_idx_t'(axi_wr_stats_pkg::NUM_STATS - 1);

  axi_wr_stats_pkg::iter_state_e state;
  axi_wr_stats_pkg::stat_idx_t   next_idx;
  logic                          xfer;

  assign xfer     = stat_iter_valid && stat_iter_ready;
  assign next_idx = rd_idx + 1'b1;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state           <= axi_wr_stats_pkg::IDLE;
      snapshot        <= 1'b0;
      rd_idx          <= '0;
      stat_iter_valid <= 1'b0;
      stat_iter_last  <= 1'b0;
    end else begin
      snapshot <= 1'b0;
      case (state)
        axi_wr_stats_pkg::IDLE: begin
          if (stat_iter_start) begin
            state    <= axi_wr_stats_pkg::SEND;
            snapshot <= 1'b1;
            rd_idx   <= '0;
          end
        end
        axi_wr_stats_pkg::SEND: begin
          // first cycle here the snapshot is being captured
          if (!stat_iter_valid) begin
            stat_iter_valid <= 1'b1;
            stat_iter_last  <= (rd_idx == LAST_IDX);
          end else if (xfer) begin
            if (stat_iter_last) begin
              stat_iter_valid <= 1'b0;
              stat_iter_last  <= 1'b0;
              state           <= axi_wr_stats_pkg::DONE;
            end else begin
              rd_idx         <= next_idx;
              stat_iter_last <= (next_idx == LAST_IDX);
            end
          end
        end
        axi_wr_stats_pkg::DONE: begin
          state <= axi_wr_stats_pkg::IDLE;
        end
        default: begin
          state <= axi_wr_stats_pkg::IDLE;
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state == axi_wr_stats_pkg::SEND && !stat_iter_valid) begin
      stat_iter_name <= axi_wr_stats_pkg::STAT_NAMES[rd_idx];
    end else if (xfer && !stat_iter_last) begin
      stat_iter_name <= axi_wr_stats_pkg::STAT_NAMES[next_idx];
    end
  end

  // value comes straight from the frozen snapshot at rd_idx
  assign stat_iter_val = rd_val;

  // a stalled record and the snapshot value under it must not change
  a_hold: assert property (
    @(posedge clk) disable iff (!rst_n)
      stat_iter_valid && !stat_iter_ready |=>
        stat_iter_valid && $stable(stat_iter_name) &&
        $stable(stat_iter_val) && $stable(stat_iter_last)
  ) else $error("stat_iterator: record changed under back-pressure");

  // last marks only a valid record at the final index
  a_last_valid: assert property (
    @(posedge clk) disable iff (!rst_n)
      stat_iter_last |-> stat_iter_valid && (rd_idx == LAST_IDX)
  ) else $error("stat_iterator: last without valid or off the final index");

endmodule

// ==== verif/axi_wr_stats_vectors.txt ====
# B awvalid awready awlen awsize wvalid wready wlast bvalid bready bresp wstrb (hex)
# E twelve expected stats in dump order, D dump, T dump under bus traffic, C clear, S stat_err
# after reset one idle cycle plus the three dump cycles are counted
E 0 0 0 0 0 0 4 0 0 0 0 0
D
S 0
C
# two bursts with stalls, slow writes, response lag and an error response
B 1 1 3 1 0 0 0 0 0 0 0
B 0 0 0 0 1 1 0 0 0 0 3
B 0 0 0 0 1 0 0 0 0 0 3
B 0 0 0 0 0 0 0 0 0 0 0
B 0 0 0 0 1 1 0 0 0 0 1
B 0 0 0 0 1 1 1 0 0 0 2
B 0 0 0 0 0 0 0 0 0 0 0
B 0 0 0 0 0 0 0 0 0 0 0
B 0 0 0 0 0 0 0 1 0 0 0
B 0 0 0 0 0 0 0 1 1 0 0
B 1 1 0 2 1 1 1 0 0 0 3
B 0 0 0 0 0 0 0 1 1 2 0
E 2 4 2 2 c 6 3 1 1 2 1 1
D
S 0
C
# snapshot stays frozen while traffic runs during the dump
B 1 1 f 3 0 0 0 0 0 0 0
B 0 0 0 0 1 1 1 0 0 0 1
B 0 0 0 0 0 0 0 1 1 3 0
E 1 1 1 1 80 1 3 0 0 0 0 1
T
C
# response with nothing outstanding
B 0 0 0 0 0 0 0 1 1 0 0
B 0 0 0 0 0 0 0 0 0 0 0
E 0 0 0 1 0 0 5 0 0 0 0 0
D
S 1
S 1
C
S 0
# counting restarts from zero, the error check above adds two idle cycles
B 1 1 1 2 0 0 0 0 0 0 0
B 0 0 0 0 1 1 0 0 0 0 3
B 0 0 0 0 1 1 1 0 0 0 3
B 0 0 0 0 0 0 0 1 1 1 0
E 1 2 1 1 8 4 5 0 0 0 0 0
D
S 0

// ==== verif/tb_axi_wr_stats.sv ====
`timescale 1ns/1ps

module tb_axi_wr_stats;

  localparam int STAT_WIDTH     = 32;
  localparam int AXI_STRB_WIDTH = 2;
  localparam int NUM_STATS      = 12;

  logic                          clk;
  logic                          rst_n;
  axi_wr_stats_pkg::axi_wr_ctl_t axi_ctl;
  logic [AXI_STRB_WIDTH-1:0]     wstrb;
  logic                          stat_clear;
  logic                          stat_iter_start;
  logic                          stat_err;
  logic                          stat_iter_valid;
  axi_wr_stats_pkg::stat_name_t  stat_iter_name;
  logic [STAT_WIDTH-1:0]         stat_iter_val;
  logic                          stat_iter_last;
  logic                          stat_iter_ready;

  logic [15:0]           lfsr;
  logic                  ready_q;
  logic [STAT_WIDTH-1:0] exp_val [NUM_STATS];
  int                    cycle_cnt;
  int                    cycle_limit;

  axi_wr_stats_top #(
    .STAT_WIDTH    (STAT_WIDTH),
    .AXI_STRB_WIDTH(AXI_STRB_WIDTH)
  ) i_dut (
    .clk            (clk),
    .rst_n          (rst_n),
    .axi_ctl        (axi_ctl),
    .wstrb          (wstrb),
    .stat_clear     (stat_clear),
    .stat_iter_start(stat_iter_start),
    .stat_err       (stat_err),
    .stat_iter_valid(stat_iter_valid),
    .stat_iter_name (stat_iter_name),
    .stat_iter_val  (stat_iter_val),
    .stat_iter_last (stat_iter_last),
    .stat_iter_ready(stat_iter_ready)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  task automatic fail_run(input string why);
    $display("%s", why);
    $display("CHECKS FAILED");
    $fatal(1);
  endtask

  task automatic check_value(input string what, input logic [127:0] actual,
                             input logic [127:0] expected);
    string msg;
    if (actual !== expected) begin
      msg = $sformatf("[FAIL] %s: actual %0h expected %0h", what, actual, expected);
      fail_run(msg);
    end
  endtask

  // 16 bit Galois LFSR stepped once per random bit
  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    if (s[0]) begin
      return (s >> 1) ^ 16'hB400;
    end
    return s >> 1;
  endfunction

  // dump order and space padded names of the statistics
  function automatic logic [127:0] stat_label(input int idx);
    case (idx)
      0:       return "aw_bursts       ";
      1:       return "w_beats         ";
      2:       return "w_bursts        ";
      3:       return "b_resps         ";
      4:       return "aw_bytes        ";
      5:       return "w_bytes         ";
      6:       return "idle_cycles     ";
      7:       return "w_stall         ";
      8:       return "w_slow          ";
      9:       return "b_lag           ";
      10:      return "b_stall         ";
      default: return "err_resps       ";
    endcase
  endfunction

  task automatic apply_bus(input axi_wr_stats_pkg::axi_wr_ctl_t ctl,
                           input logic [AXI_STRB_WIDTH-1:0] strb,
                           input logic clear, input logic start);
    @(posedge clk);
    axi_ctl         <= ctl;
    wstrb           <= strb;
    stat_clear      <= clear;
    stat_iter_start <= start;
  endtask

  task automatic clear_stats();
    apply_bus('0, '0, 1'b0, 1'b0);
    apply_bus('0, '0, 1'b1, 1'b0);
  endtask

  // two bus cycles and then the error flag as it stood before the second edge
  task automatic check_err(input logic expected);
    apply_bus('0, '0, 1'b0, 1'b0);
    apply_bus('0, '0, 1'b0, 1'b0);
    check_value("stat_err", stat_err, expected);
  endtask

  task automatic run_dump(input logic traffic);
    axi_wr_stats_pkg::axi_wr_ctl_t busy;
    int                            got;
    logic                          held;
    logic [127:0]                  held_name;
    logic [STAT_WIDTH-1:0]         held_val;
    logic                          held_last;
    logic                          rdy;
    busy         = '0;
    busy.awvalid = 1'b1;
    busy.awready = 1'b1;
    busy.awlen   = 8'd1;
    busy.wvalid  = 1'b1;
    busy.wready  = 1'b1;
    busy.wlast   = 1'b1;
    got          = 0;
    held         = 1'b0;
    apply_bus('0, '0, 1'b0, 1'b0);
    apply_bus('0, '0, 1'b0, 1'b0);
    apply_bus('0, '0, 1'b0, 1'b1);
    while (got < NUM_STATS) begin
      // outputs read here still hold their values from before the edge
      apply_bus(traffic ? busy : '0, traffic ? 2'b11 : 2'b00, 1'b0, 1'b0);
      rdy = ready_q;
      if (held) begin
        check_value("stat_iter_valid", stat_iter_valid, 1'b1);
        check_value("stat_iter_name", stat_iter_name, held_name);
        check_value("stat_iter_val", stat_iter_val, held_val);
        check_value("stat_iter_last", stat_iter_last, held_last);
      end
      if (stat_iter_valid && rdy) begin
        check_value("stat_iter_name", stat_iter_name, stat_label(got));
        check_value("stat_iter_val", stat_iter_val, exp_val[got]);
        check_value("stat_iter_last", stat_iter_last, got == NUM_STATS - 1);
        got++;
      end
      held      = stat_iter_valid && !rdy;
      held_name = stat_iter_name;
      held_val  = stat_iter_val;
      held_last = stat_iter_last;
      lfsr            = lfsr_step(lfsr);
      ready_q         = lfsr[0];
      stat_iter_ready <= ready_q;
    end
  endtask

  always @(posedge clk) begin
    cycle_cnt = cycle_cnt + 1;
    if (cycle_cnt > cycle_limit) begin
      fail_run("timeout: the run took more cycles than the vectors allow");
    end
  end

  initial begin
    int                            fd;
    int                            code;
    logic                          done;
    logic [8*16-1:0]               cmd;
    logic [8*256-1:0]              rest;
    logic [31:0]                   fld [11];
    axi_wr_stats_pkg::axi_wr_ctl_t ctl;
    rst_n           = 1'b0;
    axi_ctl         = '0;
    wstrb           = '0;
    stat_clear      = 1'b0;
    stat_iter_start = 1'b0;
    stat_iter_ready = 1'b0;
    ready_q         = 1'b0;
    lfsr            = 16'd76;
    cycle_cnt       = 0;
    cycle_limit     = 32;
    done            = 1'b0;
    repeat (10) @(posedge clk);
    rst_n <= 1'b1;
    fd = $fopen("verif/axi_wr_stats_vectors.txt", "r");
    if (fd == 0) begin
      fail_run("could not open the vector file");
    end
    while (!done) begin
      code = $fscanf(fd, "%s", cmd);
      if (code != 1) begin
        done = 1'b1;
      end else if (cmd == "#") begin
        code = $fgets(rest, fd);
      end else begin
        // each command widens the cycle budget and a dump adds room for a full stream
        cycle_limit = cycle_limit + 4;
        if (cmd == "B") begin
          code = $fscanf(fd, "%h %h %h %h %h %h %h %h %h %h %h", fld[0], fld[1], fld[2],
                         fld[3], fld[4], fld[5], fld[6], fld[7], fld[8], fld[9], fld[10]);
          if (code != 11) begin
            fail_run("a bus line in the vector file is incomplete");
          end
          ctl.awvalid = fld[0][0];
          ctl.awready = fld[1][0];
          ctl.awlen   = fld[2][7:0];
          ctl.awsize  = fld[3][2:0];
          ctl.wvalid  = fld[4][0];
          ctl.wready  = fld[5][0];
          ctl.wlast   = fld[6][0];
          ctl.bvalid  = fld[7][0];
          ctl.bready  = fld[8][0];
          ctl.bresp   = fld[9][1:0];
          apply_bus(ctl, fld[10][AXI_STRB_WIDTH-1:0], 1'b0, 1'b0);
        end else if (cmd == "E") begin
          code = $fscanf(fd, "%h %h %h %h %h %h %h %h %h %h %h %h", exp_val[0], exp_val[1],
                         exp_val[2], exp_val[3], exp_val[4], exp_val[5], exp_val[6],
                         exp_val[7], exp_val[8], exp_val[9], exp_val[10], exp_val[11]);
          if (code != NUM_STATS) begin
            fail_run("an expect line in the vector file is incomplete");
          end
        end else if (cmd == "S") begin
          code = $fscanf(fd, "%h", fld[0]);
          if (code != 1) begin
            fail_run("an error flag line in the vector file is incomplete");
          end
          check_err(fld[0][0]);
        end else if (cmd == "C") begin
          clear_stats();
        end else if (cmd == "D" || cmd == "T") begin
          cycle_limit = cycle_limit + NUM_STATS * 4;
          run_dump(cmd == "T");
        end else begin
          fail_run("unknown command in the vector file");
        end
      end
    end
    $fclose(fd);
    $display("ALL CHECKS PASSED");
    $finish;
  end

endmodule
